// ==== list.f ====
+incdir+source
source/lsu_remap_pkg.sv
source/lsu_remap_ifs.sv
source/lsu_map_fifo.sv
source/lsu_resp_fifo.sv
source/lsu_remap.sv
source/rob_result_queue.sv
source/lsu_remap_top.sv
bench/clock_gen.sv
bench/lsu_remap_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = lsu_remap_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/lsu_remap_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsu_remap_defines.svh"

module lsu_remap_tb;

  typedef struct packed {
    logic [`ROB_IDX_W-1:0]   rob;
    logic                    is_store;
    logic [`VREG_ADDR_W-1:0] vreg;
    logic [`VREG_ADDR_W-1:0] addr;
    logic [`VDATA_W-1:0]     data;
  } pair_t;

  logic                    clk, rst;
  logic                    map_push, map_is_store, map_full;
  logic [`ROB_IDX_W-1:0]   map_rob_entry, result_rob_entry;
  logic [`VREG_ADDR_W-1:0] map_vreg_addr, resp_wr_addr;
  logic                    resp_push, resp_wr_valid, resp_store_last, resp_full;
  logic [`VDATA_W-1:0]     resp_wr_data, result_w_data;
  logic                    result_valid, result_w_valid, result_ready;

  // scoreboard with the oldest expected result at the front
  logic [`ROB_IDX_W-1:0] exp_rob [$];
  logic                  exp_wv [$];
  logic [`VDATA_W-1:0]   exp_data [$];
  logic [31:0]           rng_state;
  int                    mismatches, failures, checked;

  clock_gen clk_rst (.clk, .rst);

  lsu_remap_top dut0 (.*);

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic pair_t random_pair();
    pair_t       p;
    logic [31:0] r;
    r          = next_rand();
    p.rob      = r[`ROB_IDX_W-1:0];
    p.is_store = r[8];
    p.vreg     = r[16 +: `VREG_ADDR_W];
    // one in four writes some other register
    p.addr     = (r[25:24] == 2'b00) ? ~p.vreg : p.vreg;
    p.data     = {next_rand(), next_rand()};
    return p;
  endfunction

  task automatic finish_run();
    $display("mismatches %0d, other errors %0d, results checked %0d",
             mismatches, failures, checked);
    if (mismatches == 0 && failures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    failures++;
    $display("%0t: timed out %s", $time, what);
    finish_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic drive_map(input pair_t p);
    map_push      = 1'b1;
    map_rob_entry = p.rob;
    map_is_store  = p.is_store;
    map_vreg_addr = p.vreg;
  endtask

  // legal response where a load writes and a store carries its last flag
  task automatic drive_resp(input pair_t p);
    resp_push       = 1'b1;
    resp_wr_valid   = !p.is_store;
    resp_wr_addr    = p.addr;
    resp_wr_data    = p.data;
    resp_store_last = p.is_store;
  endtask

  task automatic idle_inputs();
    map_push  = 1'b0;
    resp_push = 1'b0;
  endtask

  // the write is valid only for a load that hits its own register
  task automatic expect_result(input pair_t p);
    exp_rob.push_back(p.rob);
    exp_wv.push_back(!p.is_store && (p.addr == p.vreg));
    exp_data.push_back(p.data);
  endtask

  task automatic send_pair(input pair_t p);
    int cycles;
    cycles = 0;
    while (map_full || resp_full) begin
      if (cycles >= 200) begin
        timeout_abort("waiting for room in the input queues");
      end
      @(negedge clk);
      cycles++;
    end
    drive_map(p);
    drive_resp(p);
    expect_result(p);
    @(negedge clk);
    idle_inputs();
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while (exp_rob.size() != 0) begin
      if (cycles >= limit) begin
        timeout_abort("waiting for the expected results");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // rst only moves on falling edges, so read it on rising ones
  task automatic test_reset();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (rst) begin
      if (cycles >= 10) begin
        timeout_abort("waiting for reset release");
      end
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b0);
      check_bit("map_full", map_full, 1'b0);
      check_bit("resp_full", resp_full, 1'b0);
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    check_bit("result_valid", result_valid, 1'b0);
    check_bit("map_full", map_full, 1'b0);
    check_bit("resp_full", resp_full, 1'b0);
  endtask

  task automatic test_single_load();
    pair_t p;
    p          = random_pair();
    p.is_store = 1'b0;
    p.addr     = p.vreg;
    drive_map(p);
    @(negedge clk);
    idle_inputs();
    // response is the later push and the result is due two edges after it is driven
    drive_resp(p);
    expect_result(p);
    @(negedge clk);
    idle_inputs();
    check_bit("result_valid", result_valid, 1'b0);
    @(negedge clk);
    check_bit("result_valid", result_valid, 1'b1);
    wait_drain(20);
  endtask

  task automatic test_mismatch_store();
    pair_t p;
    p          = random_pair();
    p.is_store = 1'b0;
    p.addr     = ~p.vreg;
    send_pair(p);
    // store whose response also strobes a write to its own register
    p          = random_pair();
    p.is_store = 1'b1;
    p.addr     = p.vreg;
    drive_map(p);
    drive_resp(p);
    resp_wr_valid = 1'b1;
    expect_result(p);
    @(negedge clk);
    idle_inputs();
    wait_drain(20);
  endtask

  task automatic test_burst();
    pair_t       p;
    logic [31:0] r;
    int          sent;
    int          cycles;
    sent   = 0;
    cycles = 0;
    p      = random_pair();
    while (sent < 40) begin
      if (cycles >= 1000) begin
        timeout_abort("pushing the burst");
      end
      r = next_rand();
      // ready mostly low so the queues back up
      result_ready = r[0] & r[1];
      idle_inputs();
      if (!map_full && !resp_full && r[2]) begin
        drive_map(p);
        drive_resp(p);
        expect_result(p);
        sent++;
        p = random_pair();
      end
      @(negedge clk);
      cycles++;
    end
    idle_inputs();
    result_ready = 1'b1;
    wait_drain(300);
  endtask

  task automatic test_full_stall();
    pair_t p [8];
    for (int i = 0; i < 8; i++) begin
      p[i] = random_pair();
      drive_map(p[i]);
      @(negedge clk);
    end
    idle_inputs();
    check_bit("map_full", map_full, 1'b1);
    for (int i = 0; i < 8; i++) begin
      drive_resp(p[i]);
      expect_result(p[i]);
      @(negedge clk);
    end
    idle_inputs();
    wait_drain(100);
    check_bit("map_full", map_full, 1'b0);
  endtask

  always @(posedge clk) begin : monitor
    logic [`ROB_IDX_W-1:0] rob;
    logic                  wv;
    logic [`VDATA_W-1:0]   data;
    if (!rst && result_valid === 1'b1 && result_ready === 1'b1) begin
      if (exp_rob.size() == 0) begin
        failures++;
        $display("%0t: result for rob entry %0d arrived with none expected",
                 $time, result_rob_entry);
      end else begin
        rob  = exp_rob.pop_front();
        wv   = exp_wv.pop_front();
        data = exp_data.pop_front();
        checked++;
        if (result_rob_entry !== rob) begin
          mismatches++;
          $display("MISMATCH %0t: result_rob_entry got %0d expected %0d",
                   $time, result_rob_entry, rob);
        end
        if (result_w_valid !== wv) begin
          mismatches++;
          $display("MISMATCH %0t: result_w_valid got %b expected %b", $time, result_w_valid, wv);
        end
        if (result_w_data !== data) begin
          mismatches++;
          $display("MISMATCH %0t: result_w_data got %h expected %h", $time, result_w_data, data);
        end
      end
    end
  end

  initial begin
    rng_state       = 32'd43579;
    mismatches      = 0;
    failures        = 0;
    checked         = 0;
    map_rob_entry   = '0;
    map_is_store    = 1'b0;
    map_vreg_addr   = '0;
    resp_wr_valid   = 1'b0;
    resp_wr_addr    = '0;
    resp_wr_data    = '0;
    resp_store_last = 1'b0;
    result_ready    = 1'b1;
    idle_inputs();
    test_reset();
    test_single_load();
    test_mismatch_store();
    test_burst();
    test_full_stall();
    // room for any extra result to show up
    repeat (4) @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ns

module clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  // released on a falling edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/lsu_remap_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsu_remap_defines.svh"

module lsu_remap_top import lsu_remap_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    map_push,
  input  logic [`ROB_IDX_W-1:0]   map_rob_entry,
  input  logic                    map_is_store,
  input  logic [`VREG_ADDR_W-1:0] map_vreg_addr,
  output logic                    map_full,
  input  logic                    resp_push,
  input  logic                    resp_wr_valid,
  input  logic [`VREG_ADDR_W-1:0] resp_wr_addr,
  input  logic [`VDATA_W-1:0]     resp_wr_data,
  input  logic                    resp_store_last,
  output logic                    resp_full,
  output logic                    result_valid,
  output logic [`ROB_IDX_W-1:0]   result_rob_entry,
  output logic                    result_w_valid,
  output logic [`VDATA_W-1:0]     result_w_data,
  input  logic                    result_ready
);

  lsu_map_info_t map_rec;
  lsu_resp_t     resp_rec;
  rob_result_t   result;

  map_rd_if      map_rd ();
  resp_rd_if     resp_rd ();
  lane_result_if lane_res ();

  assign map_rec.valid     = map_push;
  assign map_rec.rob_entry = map_rob_entry;
  assign map_rec.lsu_class = map_is_store ? IS_STORE : IS_LOAD;
  assign map_rec.vreg_addr = map_vreg_addr;

  assign resp_rec.wr_valid   = resp_wr_valid;
  assign resp_rec.wr_addr    = resp_wr_addr;
  assign resp_rec.wr_data    = resp_wr_data;
  assign resp_rec.store_last = resp_store_last;

  lsu_map_fifo u_map_fifo (.clk, .rst, .push(map_push), .push_data(map_rec),
                           .full(map_full), .rd(map_rd.queue));

  lsu_resp_fifo u_resp_fifo (.clk, .rst, .push(resp_push), .push_data(resp_rec),
                             .full(resp_full), .rd(resp_rd.queue));

  lsu_remap u_remap (.map(map_rd.reader), .resp(resp_rd.reader), .res(lane_res.src));

  rob_result_queue u_result_queue (.clk, .rst, .res(lane_res.dst), .result_valid,
                                   .result, .result_ready);

  assign result_rob_entry = result.rob_entry;
  assign result_w_valid   = result.w_valid;
  assign result_w_data    = result.w_data;

endmodule

`default_nettype wire

// ==== source/rob_result_queue.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsu_remap_defines.svh"

module rob_result_queue import lsu_remap_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  lane_result_if.dst res,
  output logic        result_valid,
  output rob_result_t result,
  input  logic        result_ready
);

  localparam int DEPTH = `RESULT_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  rob_result_t         mem [DEPTH];
  logic [PTR_W-1:0]    rd_ptr;
  logic [PTR_W-1:0]    wr_ptr;
  logic [CNT_W-1:0]    count;
  logic [CNT_W-1:0]    free;
  logic [CNT_W-1:0]    push_cnt;
  logic [`NUM_LSU-1:0] xfer;
  logic                pop;

  function automatic logic [PTR_W-1:0] wrap(input int unsigned idx);
    return (idx >= DEPTH) ? PTR_W'(idx - DEPTH) : PTR_W'(idx);
  endfunction

  assign free = CNT_W'(DEPTH) - count;

  // ready from free space only, not from this cycle's drain
  always_comb begin
    for (int i = 0; i < `NUM_LSU; i++) begin
      res.ready[i] = (int'(free) > i);
    end
  end

  assign xfer = res.valid & res.ready;

  always_comb begin
    push_cnt = '0;
    for (int i = 0; i < `NUM_LSU; i++) begin
      push_cnt = push_cnt + CNT_W'(xfer[i]);
    end
  end

  assign result_valid = (count != '0);
  assign result       = mem[rd_ptr];
  assign pop          = result_valid & result_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (pop) begin
        rd_ptr <= wrap(int'(rd_ptr) + 1);
      end
      wr_ptr <= wrap(int'(wr_ptr) + int'(push_cnt));
      count  <= count + push_cnt - CNT_W'(pop);
    end
  end

  // lanes land in order behind the write pointer
  always_ff @(posedge clk) begin
    for (int i = 0; i < `NUM_LSU; i++) begin
      if (xfer[i]) begin
        mem[wrap(int'(wr_ptr) + i)] <= res.result[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_remap.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsu_remap_defines.svh"

module lsu_remap import lsu_remap_pkg::*; (
  map_rd_if.reader   map,
  resp_rd_if.reader  resp,
  lane_result_if.src res
);

  logic [`NUM_LSU-1:0] map_head_valid;
  logic [`NUM_LSU-1:0] resp_head_valid;
  logic [`NUM_LSU-1:0] lane_ok;
  logic [`NUM_LSU-1:0] lane_valid;

  genvar i;

  // queue holds more than i entries
  assign map_head_valid[0]  = !map.empty;
  assign resp_head_valid[0] = !resp.empty;

  generate
    for (i = 1; i < `NUM_LSU; i++) begin : g_head_valid
      assign map_head_valid[i]  = !(|map.almost_empty[i:0]);
      assign resp_head_valid[i] = !(|resp.almost_empty[i:0]);
    end
  endgenerate

  generate
    for (i = 0; i < `NUM_LSU; i++) begin : g_lane
      // load needs its write, store needs its last beat
      assign lane_ok[i] = map_head_valid[i] & resp_head_valid[i] & map.heads[i].valid &
                          (((map.heads[i].lsu_class == IS_LOAD) & resp.heads[i].wr_valid) |
                           ((map.heads[i].lsu_class == IS_STORE) & resp.heads[i].store_last));

      // a lane only goes when every older lane goes too
      if (i == 0) begin : g_first
        assign lane_valid[i] = lane_ok[i];
      end else begin : g_rest
        assign lane_valid[i] = lane_ok[i] & lane_valid[i-1];
      end

      assign res.result[i].rob_entry = map.heads[i].rob_entry;
      assign res.result[i].w_data    = resp.heads[i].wr_data;
      assign res.result[i].w_valid   = (map.heads[i].lsu_class == IS_LOAD) &
                                       resp.heads[i].wr_valid &
                                       (resp.heads[i].wr_addr == map.heads[i].vreg_addr);

      // pops stay a prefix since valid and ready both are
      assign map.pop[i]  = lane_valid[i] & res.ready[i];
      assign resp.pop[i] = map.pop[i];
    end
  endgenerate

  assign res.valid = lane_valid;

endmodule

`default_nettype wire

// ==== source/lsu_resp_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsu_remap_defines.svh"

module lsu_resp_fifo import lsu_remap_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      push,
  input  lsu_resp_t push_data,
  output logic      full,
  resp_rd_if.queue  rd
);

  localparam int DEPTH = `RESP_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_resp_t        mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] pop_cnt;
  logic             push_ok;

  function automatic logic [PTR_W-1:0] wrap(input int unsigned idx);
    return (idx >= DEPTH) ? PTR_W'(idx - DEPTH) : PTR_W'(idx);
  endfunction

  // a push into a full queue is lost
  assign full    = (int'(count) == DEPTH);
  assign push_ok = push && !full;

  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < `NUM_LSU; i++) begin
      pop_cnt = pop_cnt + CNT_W'(rd.pop[i]);
    end
  end

  always_comb begin
    rd.empty = (count == '0);
    for (int i = 0; i < `NUM_LSU; i++) begin
      rd.heads[i]        = mem[wrap(int'(rd_ptr) + i)];
      rd.almost_empty[i] = (int'(count) <= i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wrap(int'(wr_ptr) + 1);
      end
      rd_ptr <= wrap(int'(rd_ptr) + int'(pop_cnt));
      count  <= count + CNT_W'(push_ok) - pop_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_map_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsu_remap_defines.svh"

module lsu_map_fifo import lsu_remap_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  lsu_map_info_t push_data,
  output logic          full,
  map_rd_if.queue       rd
);

  localparam int DEPTH = `MAP_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_map_info_t    mem [DEPTH];
  lsu_map_info_t    wr_rec;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] pop_cnt;
  logic             push_ok;

  // index wrap, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] wrap(input int unsigned idx);
    return (idx >= DEPTH) ? PTR_W'(idx - DEPTH) : PTR_W'(idx);
  endfunction

  assign full    = (int'(count) == DEPTH);
  assign push_ok = push && !full;

  always_comb begin
    wr_rec       = push_data;
    wr_rec.valid = 1'b1;
  end

  // pop bits are a prefix, so a plain popcount is the advance
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < `NUM_LSU; i++) begin
      pop_cnt = pop_cnt + CNT_W'(rd.pop[i]);
    end
  end

  always_comb begin
    rd.empty = (count == '0);
    for (int i = 0; i < `NUM_LSU; i++) begin
      rd.heads[i]        = mem[wrap(int'(rd_ptr) + i)];
      rd.almost_empty[i] = (int'(count) <= i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wrap(int'(wr_ptr) + 1);
      end
      rd_ptr <= wrap(int'(rd_ptr) + int'(pop_cnt));
      count  <= count + CNT_W'(push_ok) - pop_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= wr_rec;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_remap_ifs.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsu_remap_defines.svh"

// read side of the mapping-record queue
interface map_rd_if import lsu_remap_pkg::*; ();
  // oldest entry in lane 0
  lsu_map_info_t [`NUM_LSU-1:0] heads;
  logic                         empty;
  logic          [`NUM_LSU-1:0] almost_empty;
  logic          [`NUM_LSU-1:0] pop;

  modport queue  (output heads, empty, almost_empty, input pop);
  modport reader (input heads, empty, almost_empty, output pop);
endinterface

// read side of the response queue
interface resp_rd_if import lsu_remap_pkg::*; ();
  lsu_resp_t [`NUM_LSU-1:0] heads;
  logic                     empty;
  logic      [`NUM_LSU-1:0] almost_empty;
  logic      [`NUM_LSU-1:0] pop;

  modport queue  (output heads, empty, almost_empty, input pop);
  modport reader (input heads, empty, almost_empty, output pop);
endinterface

// per-lane results from remap into the result queue
interface lane_result_if import lsu_remap_pkg::*; ();
  logic        [`NUM_LSU-1:0] valid;
  // prefix, bit i means room for i+1 entries
  logic        [`NUM_LSU-1:0] ready;
  rob_result_t [`NUM_LSU-1:0] result;

  modport src (output valid, result, input ready);
  modport dst (input valid, result, output ready);
endinterface

`default_nettype wire

// ==== source/lsu_remap_pkg.sv ====
`default_nettype none

`include "lsu_remap_defines.svh"

package lsu_remap_pkg;

  typedef enum logic {
    IS_LOAD  = 1'b0,
    IS_STORE = 1'b1
  } lsu_class_e;

  // pushed by dispatch, one per uop
  typedef struct packed {
    logic                    valid;
    logic [`ROB_IDX_W-1:0]   rob_entry;
    lsu_class_e              lsu_class;
    logic [`VREG_ADDR_W-1:0] vreg_addr;
  } lsu_map_info_t;

  // returned by the lsu in uop order
  typedef struct packed {
    logic                    wr_valid;
    logic [`VREG_ADDR_W-1:0] wr_addr;
    logic [`VDATA_W-1:0]     wr_data;
    logic                    store_last;
  } lsu_resp_t;

  typedef struct packed {
    logic [`ROB_IDX_W-1:0] rob_entry;
    logic                  w_valid;
    logic [`VDATA_W-1:0]   w_data;
  } rob_result_t;

endpackage

`default_nettype wire

// ==== source/lsu_remap_defines.svh ====
`ifndef LSU_REMAP_DEFINES_SVH
`define LSU_REMAP_DEFINES_SVH

// lanes served by the remap stage per cycle
`define NUM_LSU 2

// queue depths
`define MAP_DEPTH 8
`define RESP_DEPTH 8
`define RESULT_DEPTH 4

// field widths
`define ROB_IDX_W 3
`define VREG_ADDR_W 5
`define VDATA_W 64

`endif
